// ==== verif/ooo_core_trace.txt ====
# I <instruction word, hex>            sent in program order
# R <rd, decimal> <write-back, hex>    expected results in program order
I 00500093
R 1 00000005
I ffd00113
R 2 fffffffd
I 123451b7
R 3 12345000
I 00208233
R 4 00000002
I 402082b3
R 5 00000008
I 00317333
R 6 12345000
I 0030e3b3
R 7 12345005
I 0020c433
R 8 fffffff8
I 005094b3
R 9 00000500
I 00115533
R 10 07ffffff
I 001125b3
R 11 00000001
I fff0c613
R 12 fffffffa
I 0ff17693
R 13 000000fd
I 55506713
R 14 00000555
I 00409793
R 15 00000050
I 01c15813
R 16 0000000f
I ffe12893
R 17 00000001
I fffff937
R 18 fffff000
I 00108993
R 19 00000006
I 013989b3
R 19 0000000c
I 40198a33
R 20 00000007
I 00708013
I 00100ab3
R 21 00000005

// ==== ooo_core.f ====
hw/cpu_isa_pkg.sv
hw/cpu_bundle_pkg.sv
hw/decode_stage.sv
hw/inst_queue.sv
hw/exec_unit.sv
hw/ooo_core_top.sv
verif/ooo_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the ooo_core testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
    --top-module ooo_core_tb \
    -f ooo_core.f

# Show the simulation output and look for the pass line.
./obj_dir/Vooo_core_tb 2>&1 | tee /dev/stderr | grep -x "Regression passed" > /dev/null

// ==== verif/ooo_core_tb.sv ====
`timescale 1ns/10ps

module ooo_core_tb
    import cpu_isa_pkg::*, cpu_bundle_pkg::*;
();

    localparam int TIMEOUT = 200;

    logic       clk;
    logic       rst;
    logic       inst_req;
    logic       inst_ack;
    inst_in_t   inst;
    logic       res_req;
    logic       res_ack;
    write_d_r_t res;

    logic [LEN_INST-1:0] inst_words [$];
    write_d_r_t          expected [$];
    int                  results_seen;
    int                  pass_count;
    int                  fail_count;
    logic                stop;

    ooo_core_top #(
        .WINDOW_DEPTH (4)
    ) ooo_core_top_inst (
        .clk      (clk),
        .rst      (rst),
        .inst_req (inst_req),
        .inst_ack (inst_ack),
        .inst     (inst),
        .res_req  (res_req),
        .res_ack  (res_ack),
        .res      (res)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s at %0t ns", why, $time);
        $display("Regression failed");
        $finish;
    endtask

    task automatic load_trace();
        int                      fd;
        int                      n;
        string                   line;
        logic [LEN_INST-1:0]     word;
        logic [LEN_REG_ADDR-1:0] rd;
        logic [LEN_WORD-1:0]     value;
        write_d_r_t              want;
        fd = $fopen("verif/ooo_core_trace.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open the trace file");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.getc(0) == "I") begin
                    n = $sscanf(line, "I %h", word);
                    if (n != 1) abort_run("malformed instruction line in trace");
                    inst_words.push_back(word);
                end else if (line.getc(0) == "R") begin
                    n = $sscanf(line, "R %d %h", rd, value);
                    if (n != 2) abort_run("malformed result line in trace");
                    want.order = 1'b1;
                    want.rd    = rd;
                    want.d_rd  = value;
                    expected.push_back(want);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_result(input write_d_r_t got, input write_d_r_t want);
        if (got === want) begin
            pass_count++;
            $display("test %0d: x%0d = %h ok", results_seen, got.rd, got.d_rd);
        end else begin
            fail_count++;
            $display("ERROR %0t ns: res got %0b/%0d/%h expected %0b/%0d/%h (order/rd/d_rd)",
                     $time, got.order, got.rd, got.d_rd, want.order, want.rd, want.d_rd);
        end
    endtask

    // four-phase send on the inst port after a random gap
    task automatic send_inst(input logic [LEN_INST-1:0] word);
        int gap;
        int n;
        gap = $urandom_range(3, 0);
        repeat (gap) @(posedge clk);
        @(posedge clk);
        inst.word <= word;
        inst_req  <= 1'b1;
        n = 0;
        // stays low while decode stalls on a hazard
        while (!inst_ack) begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT) abort_run("inst_ack never rose");
        end
        inst_req <= 1'b0;
        n = 0;
        while (inst_ack) begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT) abort_run("inst_ack never dropped");
        end
    endtask

    // answers write-backs with a random ack delay
    initial begin
        int idle;
        int delay;
        int n;
        res_ack = 1'b0;
        @(posedge clk);
        n = 0;
        while (rst !== 1'b0) begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT) abort_run("reset never released");
        end
        while (!stop) begin
            idle = 0;
            while (!res_req && !stop) begin
                @(posedge clk);
                if (results_seen < expected.size()) idle++;
                if (idle > TIMEOUT) abort_run("no write-back arrived");
            end
            if (!stop) begin
                if (results_seen < expected.size()) begin
                    check_result(res, expected[results_seen]);
                end else begin
                    fail_count++;
                    $display("unexpected write-back to x%0d beyond the trace", res.rd);
                end
                results_seen++;
                // long delays back the queue up
                delay = $urandom_range(15, 0);
                repeat (delay) @(posedge clk);
                res_ack <= 1'b1;
                n = 0;
                while (res_req) begin
                    @(posedge clk);
                    n++;
                    if (n > TIMEOUT) abort_run("res_req never dropped");
                end
                res_ack <= 1'b0;
            end
        end
    end

    initial begin
        int n;
        int last;
        void'($urandom(32'h6959a087));
        rst          = 1'b1;
        inst_req     = 1'b0;
        inst         = '0;
        stop         = 1'b0;
        results_seen = 0;
        pass_count   = 0;
        fail_count   = 0;
        load_trace();
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        foreach (inst_words[i]) begin
            send_inst(inst_words[i]);
        end

        last = results_seen;
        n    = 0;
        while (results_seen < expected.size()) begin
            @(posedge clk);
            if (results_seen != last) begin
                last = results_seen;
                n    = 0;
            end else begin
                n++;
            end
            if (n > TIMEOUT) abort_run("write-backs stopped before the trace end");
        end

        // any write-back after the last trace entry counts as extra
        repeat (TIMEOUT) @(posedge clk);
        stop = 1'b1;

        if (expected.size() > 0 && results_seen == expected.size()) begin
            pass_count++;
            $display("test %0d: result count %0d ok", results_seen + 1, results_seen);
        end else begin
            fail_count++;
            $display("result count wrong, got %0d while the trace has %0d",
                     results_seen, expected.size());
        end

        $display("%0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== hw/ooo_core_top.sv ====
`timescale 1ns/10ps

module ooo_core_top
    import cpu_bundle_pkg::*;
#(
    parameter int WINDOW_DEPTH = 4
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       inst_req,
    output logic       inst_ack,
    input  inst_in_t   inst,
    output logic       res_req,
    input  logic       res_ack,
    output write_d_r_t res
);

    logic       dec_req;
    logic       dec_ack;
    exec_info_t dec_info;
    logic       iss_req;
    logic       iss_ack;
    exec_info_t iss_info;
    write_d_r_t wb;

    decode_stage decode_stage_inst (
        .clk      (clk),
        .rst      (rst),
        .inst_req (inst_req),
        .inst_ack (inst_ack),
        .inst     (inst),
        .dec_req  (dec_req),
        .dec_ack  (dec_ack),
        .dec_info (dec_info),
        .wb       (wb)
    );

    inst_queue #(
        .WINDOW_DEPTH (WINDOW_DEPTH)
    ) inst_queue_inst (
        .clk      (clk),
        .rst      (rst),
        .dec_req  (dec_req),
        .dec_ack  (dec_ack),
        .dec_info (dec_info),
        .iss_req  (iss_req),
        .iss_ack  (iss_ack),
        .iss_info (iss_info)
    );

    exec_unit exec_unit_inst (
        .clk      (clk),
        .rst      (rst),
        .iss_req  (iss_req),
        .iss_ack  (iss_ack),
        .iss_info (iss_info),
        .res_req  (res_req),
        .res_ack  (res_ack),
        .res      (res),
        .wb       (wb)
    );

endmodule

// ==== hw/exec_unit.sv ====
`timescale 1ns/10ps

module exec_unit
    import cpu_isa_pkg::*, cpu_bundle_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       iss_req,
    output logic       iss_ack,
    input  exec_info_t iss_info,
    output logic       res_req,
    input  logic       res_ack,
    output write_d_r_t res,
    output write_d_r_t wb
);

    typedef enum logic [1:0] {
        ex_idle,
        ex_ack_in,
        ex_hold_res,
        ex_wait_drop
    } ex_state_e;

    ex_state_e state;

    write_d_r_t           res_q;
    logic [LEN_WORD-1:0]  op_a;
    logic [LEN_WORD-1:0]  op_b;
    logic [LEN_SHAMT-1:0] shamt;
    logic                 is_sub;
    logic                 lt;
    logic [LEN_WORD-1:0]  alu_out;
    logic [LEN_WORD-1:0]  result;
    logic                 take;

    always_comb begin
        op_a   = iss_info.d_rs1;
        op_b   = iss_info.d_rs2;
        shamt  = op_b[LEN_SHAMT-1:0];
        is_sub = is_alu_std(iss_info.exec_type) && (iss_info.func7 == FUNC7_ALT);
        lt     = $signed(op_a) < $signed(op_b);
        case (iss_info.func3)
            f3_add:  alu_out = is_sub ? op_a - op_b : op_a + op_b;
            f3_sll:  alu_out = op_a << shamt;
            f3_slt:  alu_out = {{(LEN_WORD-1){1'b0}}, lt};
            f3_xor:  alu_out = op_a ^ op_b;
            f3_srl:  alu_out = op_a >> shamt;
            f3_or:   alu_out = op_a | op_b;
            f3_and:  alu_out = op_a & op_b;
            default: alu_out = '0;
        endcase
        // lui carries its value in d_rs2
        if (iss_info.exec_type.subst) begin
            result = op_b;
        end else if (is_alu_std(iss_info.exec_type) || is_alu_imm(iss_info.exec_type)) begin
            result = alu_out;
        end else begin
            result = '0;
        end
    end

    assign take    = (state == ex_idle) && iss_req && !iss_ack;
    assign res_req = (state == ex_hold_res);
    assign res     = res_q;
    // one-cycle pulse while the outside acks
    assign wb      = (res_req && res_ack) ? res_q : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ex_idle;
            iss_ack <= 1'b0;
        end else begin
            if (take) begin
                iss_ack <= 1'b1;
            end else if (iss_ack && !iss_req) begin
                iss_ack <= 1'b0;
            end
            case (state)
                ex_idle:      if (take) state <= ex_ack_in;
                // silent retire for rd = x0
                ex_ack_in:    state <= res_q.order ? ex_hold_res : ex_wait_drop;
                ex_hold_res:  if (res_ack) state <= ex_wait_drop;
                ex_wait_drop: if (!res_ack && !iss_ack) state <= ex_idle;
                default:      state <= ex_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            res_q.order <= iss_info.rd_order;
            res_q.rd    <= iss_info.rd;
            res_q.d_rd  <= result;
        end
    end

    res_stable: assert property (@(posedge clk) disable iff (rst)
        res_req && !res_ack |=> $stable(res));

endmodule

// ==== hw/inst_queue.sv ====
`timescale 1ns/10ps

module inst_queue
    import cpu_bundle_pkg::*;
#(
    parameter int WINDOW_DEPTH = 4
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       dec_req,
    output logic       dec_ack,
    input  exec_info_t dec_info,
    output logic       iss_req,
    input  logic       iss_ack,
    output exec_info_t iss_info
);

    localparam int PTR_W = $clog2(WINDOW_DEPTH);

    typedef enum logic {
        in_idle,
        in_ack
    } in_state_e;

    typedef enum logic [1:0] {
        out_idle,
        out_req,
        out_drop
    } out_state_e;

    in_state_e  in_state;
    out_state_e out_state;

    exec_info_t       mem [WINDOW_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             full;
    logic             empty;
    logic             push;
    logic             pop;

    assign full  = (count == WINDOW_DEPTH[PTR_W:0]);
    assign empty = (count == '0);
    assign push  = (in_state == in_idle) && dec_req && !full;
    assign pop   = (out_state == out_req) && iss_ack;

    assign dec_ack  = (in_state == in_ack);
    assign iss_req  = (out_state == out_req);
    // head entry stays put until popped
    assign iss_info = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            in_state  <= in_idle;
            out_state <= out_idle;
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
        end else begin
            case (in_state)
                in_idle: if (push) in_state <= in_ack;
                in_ack:  if (!dec_req) in_state <= in_idle;
                default: in_state <= in_idle;
            endcase
            case (out_state)
                out_idle: if (!empty) out_state <= out_req;
                out_req:  if (iss_ack) out_state <= out_drop;
                out_drop: if (!iss_ack) out_state <= out_idle;
                default:  out_state <= out_idle;
            endcase
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= dec_info;
        end
    end

    no_write_when_full: assert property (@(posedge clk) disable iff (rst)
        (count <= WINDOW_DEPTH[PTR_W:0]) && (wr_ptr - rd_ptr == count[PTR_W-1:0]));

    iss_info_stable: assert property (@(posedge clk) disable iff (rst)
        iss_req && !iss_ack |=> $stable(iss_info));

endmodule

// ==== hw/decode_stage.sv ====
`timescale 1ns/10ps

module decode_stage
    import cpu_isa_pkg::*, cpu_bundle_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       inst_req,
    output logic       inst_ack,
    input  inst_in_t   inst,
    output logic       dec_req,
    input  logic       dec_ack,
    output exec_info_t dec_info,
    input  write_d_r_t wb
);

    typedef enum logic [1:0] {
        dec_idle,
        dec_load,
        dec_wait_ack,
        dec_wait_drop
    } dec_state_e;

    dec_state_e dec_state;

    logic [LEN_WORD-1:0] regs [NUM_REGS];
    logic [NUM_REGS-1:0] busy;

    opcode_e                 opcode;
    logic [LEN_REG_ADDR-1:0] rs1;
    logic [LEN_REG_ADDR-1:0] rs2;
    logic [LEN_REG_ADDR-1:0] rd;
    logic [LEN_WORD-1:0]     imm_i;
    logic [LEN_WORD-1:0]     imm_u;
    logic [LEN_WORD-1:0]     d_rs1;
    logic [LEN_WORD-1:0]     d_rs2;
    logic                    use_rs1;
    logic                    use_rs2;
    logic                    valid_op;
    logic                    hazard;
    logic                    accept;
    exec_info_t              dec_next;

    always_comb begin
        opcode = opcode_e'(inst.word[OPCODE_LSB +: LEN_OPCODE]);
        rs1    = inst.word[RS1_LSB +: LEN_REG_ADDR];
        rs2    = inst.word[RS2_LSB +: LEN_REG_ADDR];
        rd     = inst.word[RD_LSB +: LEN_REG_ADDR];
        imm_i  = {{(LEN_WORD - IMM_I_LEN){inst.word[LEN_INST-1]}},
                  inst.word[IMM_I_LSB +: IMM_I_LEN]};
        imm_u  = {inst.word[IMM_U_LSB +: IMM_U_LEN], {(LEN_WORD - IMM_U_LEN){1'b0}}};
        // x0 always reads zero
        d_rs1  = (rs1 == '0) ? '0 : regs[rs1];
        d_rs2  = (rs2 == '0) ? '0 : regs[rs2];

        use_rs1  = 1'b0;
        use_rs2  = 1'b0;
        valid_op = 1'b0;
        dec_next = '0;
        dec_next.func3 = alu_func3_e'(inst.word[FUNC3_LSB +: LEN_FUNC3]);
        dec_next.func7 = inst.word[FUNC7_LSB +: LEN_FUNC7];
        dec_next.rd    = rd;
        dec_next.d_rs1 = d_rs1;
        case (opcode)
            op_reg: begin
                dec_next.exec_type.alu_non_imm = 1'b1;
                dec_next.exec_type.alu_non_ext = 1'b1;
                dec_next.d_rs2 = d_rs2;
                use_rs1  = 1'b1;
                use_rs2  = 1'b1;
                valid_op = 1'b1;
            end
            op_imm: begin
                dec_next.exec_type.alu_non_ext = 1'b1;
                dec_next.d_rs2 = imm_i;
                use_rs1  = 1'b1;
                valid_op = 1'b1;
            end
            op_lui: begin
                dec_next.exec_type.subst = 1'b1;
                dec_next.d_rs2 = imm_u;
                valid_op = 1'b1;
            end
            default: ;
        endcase
        // unknown opcodes and rd = x0 retire without write-back
        dec_next.rd_order = valid_op && (rd != '0);

        // raw on sources, waw on destination
        hazard = (use_rs1 && busy[rs1]) || (use_rs2 && busy[rs2]) ||
                 (dec_next.rd_order && busy[rd]);
        accept = inst_req && !inst_ack && (dec_state == dec_idle) && !hazard;
    end

    assign dec_req = (dec_state == dec_wait_ack);

    // handshake on both sides
    always_ff @(posedge clk) begin
        if (rst) begin
            inst_ack  <= 1'b0;
            dec_state <= dec_idle;
        end else begin
            if (accept) begin
                inst_ack <= 1'b1;
            end else if (inst_ack && !inst_req) begin
                inst_ack <= 1'b0;
            end
            case (dec_state)
                dec_idle:      if (accept) dec_state <= dec_load;
                dec_load:      dec_state <= dec_wait_ack;
                dec_wait_ack:  if (dec_ack) dec_state <= dec_wait_drop;
                dec_wait_drop: if (!dec_ack) dec_state <= dec_idle;
                default:       dec_state <= dec_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dec_info <= dec_next;
        end
    end

    // scoreboard and register file
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb.order) begin
                busy[wb.rd] <= 1'b0;
                if (wb.rd != '0) begin
                    regs[wb.rd] <= wb.d_rd;
                end
            end
            if (accept && dec_next.rd_order) begin
                busy[rd] <= 1'b1;
            end
        end
    end

    inst_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        inst_ack |-> $past(inst_req));

endmodule

// ==== hw/cpu_bundle_pkg.sv ====
package cpu_bundle_pkg;

    import cpu_isa_pkg::*;

    // exec class bits
    typedef struct packed {
        logic alu_non_imm;
        logic alu_non_ext;
        logic subst;
    } exec_type_t;

    // external instruction request
    typedef struct packed {
        logic [LEN_INST-1:0] word;
    } inst_in_t;

    // decode -> queue -> exec
    typedef struct packed {
        exec_type_t                exec_type;
        alu_func3_e                func3;
        logic [LEN_FUNC7-1:0]      func7;
        logic                      rd_order;
        logic [LEN_REG_ADDR-1:0]   rd;
        logic [LEN_WORD-1:0]       d_rs1;
        logic [LEN_WORD-1:0]       d_rs2;
    } exec_info_t;

    // exec -> register file and outside
    typedef struct packed {
        logic                      order;
        logic [LEN_REG_ADDR-1:0]   rd;
        logic [LEN_WORD-1:0]       d_rd;
    } write_d_r_t;

    // register-register alu op
    function automatic logic is_alu_std(exec_type_t t);
        return t.alu_non_ext & t.alu_non_imm;
    endfunction

    // register-immediate alu op
    function automatic logic is_alu_imm(exec_type_t t);
        return t.alu_non_ext & ~t.alu_non_imm;
    endfunction

    // any alu op
    function automatic logic is_alu(exec_type_t t);
        return t.alu_non_ext | t.alu_non_imm;
    endfunction

endpackage

// ==== hw/cpu_isa_pkg.sv ====
package cpu_isa_pkg;

    // basic widths
    localparam int LEN_WORD     = 32;
    localparam int LEN_INST     = 32;
    localparam int LEN_REG_ADDR = 5;
    localparam int LEN_OPCODE   = 7;
    localparam int LEN_FUNC3    = 3;
    localparam int LEN_FUNC7    = 7;

    localparam int NUM_REGS = 2 ** LEN_REG_ADDR;

    // major opcodes handled by this back end
    typedef enum logic [LEN_OPCODE-1:0] {
        op_reg = 7'b0110011,
        op_imm = 7'b0010011,
        op_lui = 7'b0110111
    } opcode_e;

    // func3 encodings of the integer ALU group
    typedef enum logic [LEN_FUNC3-1:0] {
        f3_add = 3'b000,
        f3_sll = 3'b001,
        f3_slt = 3'b010,
        f3_xor = 3'b100,
        f3_srl = 3'b101,
        f3_or  = 3'b110,
        f3_and = 3'b111
    } alu_func3_e;

    // func7 selecting sub over add
    localparam logic [LEN_FUNC7-1:0] FUNC7_ALT = 7'b0100000;

    // instruction field positions
    localparam int OPCODE_LSB = 0;
    localparam int RD_LSB     = 7;
    localparam int FUNC3_LSB  = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int FUNC7_LSB  = 25;

    // I-type immediate and U-type upper part
    localparam int IMM_I_LSB = 20;
    localparam int IMM_I_LEN = 12;
    localparam int IMM_U_LSB = 12;
    localparam int IMM_U_LEN = 20;

    // shift amount field
    localparam int LEN_SHAMT = 5;

endpackage
